// ==== include/tag_mem_defs.svh ====
// values must match the air interface decoder and the three-bank memory macro
`ifndef TAG_MEM_DEFS_SVH
`define TAG_MEM_DEFS_SVH

`define TAG_WORD_W          16
`define TAG_ADDR_W          6
`define TAG_BANK_DEPTH      64

// one-hot command vector from the decoder
`define RX_CMD_W            13
`define CMD_BIT_SELECT      4
`define CMD_BIT_READ        7
`define CMD_BIT_SENSOR_READ 11

`define MEMBANK_EPC         2'd1
`define SELECT_CODE_ADDR    6'd2

`endif

// ==== src/tag_mem_pkg.sv ====
// widths come from tag_mem_defs.svh so the include path must reach include/
`default_nettype none
`include "tag_mem_defs.svh"

package tag_mem_pkg;

    typedef logic [`TAG_WORD_W-1:0] word_t;
    typedef logic [`TAG_ADDR_W-1:0] word_addr_t;

    // one-hot bank lines of the macro
    typedef enum logic [2:0] {
        bank_epc     = 3'b001,
        bank_sensor1 = 3'b010,
        bank_sensor2 = 3'b100
    } mem_bank_t;

    typedef logic [2:0] sel_target_t;  // 0..3 session, 4 sl
    typedef logic [2:0] sel_action_t;
    typedef logic [1:0] session_t;
    typedef logic [2:0] sensor_code_t; // 1 and 2 valid, rest unused

endpackage

`default_nettype wire

// ==== src/select_flags.sv ====
// flags change only on code_valid and the mask is compared with the whole 16-bit code word
`timescale 1ns/1ps
`default_nettype none
`include "tag_mem_defs.svh"

module select_flags import tag_mem_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        select_req,
    input  sel_target_t sel_target,
    input  sel_action_t sel_action,
    input  word_t       mask,
    input  logic        code_valid,
    input  word_t       code_word,
    output session_t    session,
    output logic        sl_flag,
    output logic        inven_flag
);

    typedef enum logic [1:0] {
        FLAG_KEEP,
        FLAG_SET,
        FLAG_CLR,
        FLAG_TGL
    } flag_op_t;

    sel_target_t target_q;
    sel_action_t action_q;
    word_t       mask_q;
    logic        hit;
    flag_op_t    flag_op;

    assign hit = (mask_q == code_word);

    // action table
    always_comb begin
        flag_op = FLAG_KEEP;
        if (hit) begin
            case (action_q)
                3'd0, 3'd1: flag_op = FLAG_SET;
                3'd3:       flag_op = FLAG_TGL;
                3'd4, 3'd5: flag_op = FLAG_CLR;
                default:    flag_op = FLAG_KEEP;
            endcase
        end else begin
            case (action_q)
                3'd0, 3'd2: flag_op = FLAG_CLR;
                3'd4, 3'd6: flag_op = FLAG_SET;
                3'd7:       flag_op = FLAG_TGL;
                default:    flag_op = FLAG_KEEP;
            endcase
        end
    end

    function automatic logic apply_op(input flag_op_t op, input logic cur);
        case (op)
            FLAG_SET: apply_op = 1'b1;
            FLAG_CLR: apply_op = 1'b0;
            FLAG_TGL: apply_op = ~cur;
            default:  apply_op = cur;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (select_req) begin
            target_q <= sel_target;
            action_q <= sel_action;
            mask_q   <= mask;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            session    <= '0;
            sl_flag    <= 1'b1;
            inven_flag <= 1'b1;
        end else begin
            if (select_req && (sel_target < 3'd4)) begin
                session <= sel_target[1:0];
            end
            if (code_valid) begin
                if (target_q < 3'd4) begin
                    inven_flag <= apply_op(flag_op, inven_flag);
                end else if (target_q == 3'd4) begin
                    sl_flag <= apply_op(flag_op, sl_flag);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/bank_sequencer.sv ====
// one word per start and start is ignored while busy; done comes 6 cycles after the start edge
`timescale 1ns/1ps
`default_nettype none
`include "tag_mem_defs.svh"

module bank_sequencer import tag_mem_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  logic       write,
    input  mem_bank_t  bank,
    input  word_addr_t addr,
    input  word_t      wr_data,
    output logic       busy,
    output logic       done,
    output word_t      rd_data,
    output mem_bank_t  mem_sel,
    output word_addr_t mem_address,
    output word_t      mem_data_out,
    output logic       pc_b,
    output logic       se,
    output logic       we,
    input  word_t      mem_read_in
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_BANK,
        S_PRECHARGE,
        S_ADDR,
        S_STROBE,
        S_CAPTURE,
        S_FINISH
    } state_t;

    state_t     state;
    logic       wr_q;
    word_addr_t addr_q;
    word_t      data_q;

    assign busy = (state != S_IDLE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_IDLE;
            wr_q  <= 1'b0;
            pc_b  <= 1'b1;
            se    <= 1'b0;
            we    <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        wr_q  <= write;
                        state <= S_BANK;
                    end
                end
                S_BANK: begin
                    pc_b  <= 1'b0;      // precharge off for the access
                    state <= S_PRECHARGE;
                end
                S_PRECHARGE: begin
                    state <= S_ADDR;
                end
                S_ADDR: begin
                    se    <= ~wr_q;
                    we    <= wr_q;
                    state <= S_STROBE;
                end
                S_STROBE: begin
                    se    <= 1'b0;
                    we    <= 1'b0;
                    state <= S_CAPTURE;
                end
                S_CAPTURE: begin
                    pc_b  <= 1'b1;
                    state <= S_FINISH;
                end
                S_FINISH: begin
                    done  <= 1'b1;
                    state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // macro address and data lines hold until the next access
    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: begin
                if (start) begin
                    mem_sel <= bank;
                    addr_q  <= addr;
                    data_q  <= wr_data;
                end
            end
            S_PRECHARGE: begin
                mem_address <= addr_q;
                if (wr_q) begin
                    mem_data_out <= data_q;
                end
            end
            S_STROBE: begin
                if (!wr_q) begin
                    rd_data <= mem_read_in;  // valid while se is high
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/command_ctrl.sv ====
// packets are dropped unless idle and a new ADC sample replaces one still pending
`timescale 1ns/1ps
`default_nettype none
`include "tag_mem_defs.svh"

module command_ctrl import tag_mem_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 packet_complete,
    input  logic [`RX_CMD_W-1:0] rx_cmd,
    input  logic [1:0]           membank,
    input  logic [7:0]           read_ptr,
    input  logic [7:0]           read_count,
    input  sensor_code_t         sensor_code,
    input  logic                 adc_ready,
    input  logic [7:0]           adc_data,
    input  logic [7:0]           time_stamp,
    output logic                 select_req,
    output logic                 code_valid,
    output logic                 seq_start,
    output logic                 seq_write,
    output mem_bank_t            seq_bank,
    output word_addr_t           seq_addr,
    output word_t                seq_wr_data,
    input  logic                 seq_busy,
    input  logic                 seq_done,
    input  word_t                seq_rd_data,
    input  logic                 ser_ready,
    output logic                 ser_load,
    output logic                 ser_last,
    output logic                 mem_done
);

    localparam logic [`TAG_ADDR_W:0] BANK_FULL = `TAG_BANK_DEPTH;

    logic [`TAG_ADDR_W:0] cnt_s1;
    logic [`TAG_ADDR_W:0] cnt_s2;
    logic [`TAG_ADDR_W:0] adc_cnt;
    logic [`TAG_ADDR_W:0] sensor_cnt;
    logic                 adc_pend;
    logic                 adc_s2;
    word_t                adc_word;
    logic                 wr_go;
    logic                 sel_pend;
    logic [7:0]           rd_left;
    word_addr_t           rd_addr;
    mem_bank_t            rd_bank;
    logic                 rd_step;
    logic                 inflight;
    logic                 op_wr;
    logic                 op_sel;
    logic                 idle;
    logic                 accept;
    logic                 epc_bank;
    logic                 sensor_ok;
    logic                 rd_epc;
    logic                 rd_sensor;
    logic [7:0]           epc_top;

    assign adc_cnt    = adc_s2 ? cnt_s2 : cnt_s1;
    assign wr_go      = adc_pend && (adc_cnt < BANK_FULL);
    assign sensor_ok  = (sensor_code == 3'd1) || (sensor_code == 3'd2);
    assign sensor_cnt = (sensor_code == 3'd2) ? cnt_s2 : cnt_s1;
    assign epc_bank   = (membank == `MEMBANK_EPC);
    assign epc_top    = read_ptr + read_count - 8'd1;

    assign idle      = !inflight && !seq_busy && (rd_left == 8'd0) && !sel_pend;
    assign accept    = packet_complete && idle;
    assign rd_epc    = accept && rx_cmd[`CMD_BIT_READ] && epc_bank && (read_count != 8'd0);
    assign rd_sensor = accept && rx_cmd[`CMD_BIT_SENSOR_READ] && sensor_ok;

    assign select_req = accept && rx_cmd[`CMD_BIT_SELECT] && epc_bank;

    // sample write first, then the select code word, then read words
    assign seq_start   = !inflight && !seq_busy
                         && (wr_go || sel_pend || ((rd_left != 8'd0) && ser_ready));
    assign rd_step     = seq_start && !wr_go && !sel_pend;
    assign seq_write   = wr_go;
    assign seq_bank    = wr_go ? (adc_s2 ? bank_sensor2 : bank_sensor1)
                               : (sel_pend ? bank_epc : rd_bank);
    assign seq_addr    = wr_go ? adc_cnt[`TAG_ADDR_W-1:0]
                               : (sel_pend ? `SELECT_CODE_ADDR : rd_addr);
    assign seq_wr_data = adc_word;

    assign code_valid = seq_done && op_sel;
    assign mem_done   = seq_done && op_wr;
    assign ser_load   = seq_done && !op_wr && !op_sel;
    assign ser_last   = (rd_left == 8'd0);  // counted down at start

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt_s1   <= '0;
            cnt_s2   <= '0;
            adc_pend <= 1'b0;
            sel_pend <= 1'b0;
            rd_left  <= '0;
            inflight <= 1'b0;
            op_wr    <= 1'b0;
            op_sel   <= 1'b0;
        end else begin
            if (seq_start) begin
                inflight <= 1'b1;
                op_wr    <= wr_go;
                op_sel   <= !wr_go && sel_pend;
                if (wr_go) begin
                    adc_pend <= 1'b0;
                    if (adc_s2) begin
                        cnt_s2 <= cnt_s2 + 1'b1;
                    end else begin
                        cnt_s1 <= cnt_s1 + 1'b1;
                    end
                end else if (!sel_pend) begin
                    rd_left <= rd_left - 8'd1;
                end
            end else if (adc_pend && !wr_go) begin
                adc_pend <= 1'b0;  // bank full
            end
            if (seq_done) begin
                inflight <= 1'b0;
                if (op_sel) begin
                    sel_pend <= 1'b0;
                end
            end
            if (adc_ready && sensor_ok) begin
                adc_pend <= 1'b1;
            end
            if (select_req) begin
                sel_pend <= 1'b1;
            end else if (rd_epc) begin
                rd_left <= read_count;
            end else if (rd_sensor) begin
                rd_left <= {1'b0, sensor_cnt};  // empty bank sends nothing
            end
        end
    end

    always_ff @(posedge clk) begin
        if (adc_ready && sensor_ok) begin
            adc_word <= {time_stamp, adc_data};
            adc_s2   <= (sensor_code == 3'd2);
        end
        if (rd_epc) begin
            rd_addr <= epc_top[`TAG_ADDR_W-1:0];  // highest word first
            rd_bank <= bank_epc;
        end else if (rd_sensor) begin
            rd_addr <= sensor_cnt[`TAG_ADDR_W-1:0] - 1'b1;
            rd_bank <= (sensor_code == 3'd2) ? bank_sensor2 : bank_sensor1;
        end else if (rd_step) begin
            rd_addr <= rd_addr - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/word_serializer.sv ====
// ready is low while a word shifts out and a load on the last bit continues the stream
`timescale 1ns/1ps
`default_nettype none
`include "tag_mem_defs.svh"

module word_serializer import tag_mem_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  load,
    input  logic  last,
    input  word_t word,
    output logic  ready,
    output logic  tx_bit,
    output logic  tx_bit_valid,
    output logic  tx_data_done
);

    word_t      shift_q;
    logic [3:0] bit_cnt;
    logic       last_q;
    logic       last_bit;

    assign last_bit     = tx_bit_valid && (bit_cnt == 4'd15);
    assign ready        = !tx_bit_valid || last_bit;
    assign tx_bit       = shift_q[0];  // lsb first
    assign tx_data_done = last_bit && last_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bit_cnt      <= '0;
            tx_bit_valid <= 1'b0;
            last_q       <= 1'b0;
        end else if (load && ready) begin
            bit_cnt      <= '0;
            tx_bit_valid <= 1'b1;
            last_q       <= last;
        end else if (tx_bit_valid) begin
            bit_cnt <= bit_cnt + 4'd1;
            if (last_bit) begin
                tx_bit_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load && ready) begin
            shift_q <= word;
        end else if (tx_bit_valid) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

`default_nettype wire

// ==== src/tag_mem_top.sv ====
// the macro must drive mem_read_in combinationally while se is high
`timescale 1ns/1ps
`default_nettype none
`include "tag_mem_defs.svh"

module tag_mem_top import tag_mem_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 packet_complete,
    input  logic [`RX_CMD_W-1:0] rx_cmd,
    input  sel_target_t          sel_target,
    input  sel_action_t          sel_action,
    input  word_t                mask,
    input  logic [1:0]           membank,
    input  logic [7:0]           read_ptr,
    input  logic [7:0]           read_count,
    input  sensor_code_t         sensor_code,
    input  logic                 adc_ready,
    input  logic [7:0]           adc_data,
    input  logic [7:0]           time_stamp,
    input  word_t                mem_read_in,
    output word_t                mem_data_out,
    output word_addr_t           mem_address,
    output mem_bank_t            mem_sel,
    output logic                 pc_b,
    output logic                 se,
    output logic                 we,
    output logic                 tx_bit,
    output logic                 tx_bit_valid,
    output logic                 tx_data_done,
    output logic                 mem_done,
    output logic                 sl_flag,
    output logic                 inven_flag,
    output session_t             session
);

    logic       select_req;
    logic       code_valid;
    logic       seq_start;
    logic       seq_write;
    mem_bank_t  seq_bank;
    word_addr_t seq_addr;
    word_t      seq_wr_data;
    logic       seq_busy;
    logic       seq_done;
    word_t      seq_rd_data;
    logic       ser_ready;
    logic       ser_load;
    logic       ser_last;

    command_ctrl u_command_ctrl (
        .clk             (clk),
        .reset           (reset),
        .packet_complete (packet_complete),
        .rx_cmd          (rx_cmd),
        .membank         (membank),
        .read_ptr        (read_ptr),
        .read_count      (read_count),
        .sensor_code     (sensor_code),
        .adc_ready       (adc_ready),
        .adc_data        (adc_data),
        .time_stamp      (time_stamp),
        .select_req      (select_req),
        .code_valid      (code_valid),
        .seq_start       (seq_start),
        .seq_write       (seq_write),
        .seq_bank        (seq_bank),
        .seq_addr        (seq_addr),
        .seq_wr_data     (seq_wr_data),
        .seq_busy        (seq_busy),
        .seq_done        (seq_done),
        .seq_rd_data     (seq_rd_data),
        .ser_ready       (ser_ready),
        .ser_load        (ser_load),
        .ser_last        (ser_last),
        .mem_done        (mem_done)
    );

    bank_sequencer u_bank_sequencer (
        .clk          (clk),
        .reset        (reset),
        .start        (seq_start),
        .write        (seq_write),
        .bank         (seq_bank),
        .addr         (seq_addr),
        .wr_data      (seq_wr_data),
        .busy         (seq_busy),
        .done         (seq_done),
        .rd_data      (seq_rd_data),
        .mem_sel      (mem_sel),
        .mem_address  (mem_address),
        .mem_data_out (mem_data_out),
        .pc_b         (pc_b),
        .se           (se),
        .we           (we),
        .mem_read_in  (mem_read_in)
    );

    word_serializer u_word_serializer (
        .clk          (clk),
        .reset        (reset),
        .load         (ser_load),
        .last         (ser_last),
        .word         (seq_rd_data),
        .ready        (ser_ready),
        .tx_bit       (tx_bit),
        .tx_bit_valid (tx_bit_valid),
        .tx_data_done (tx_data_done)
    );

    // code word comes straight from the sequencer read data
    select_flags u_select_flags (
        .clk        (clk),
        .reset      (reset),
        .select_req (select_req),
        .sel_target (sel_target),
        .sel_action (sel_action),
        .mask       (mask),
        .code_valid (code_valid),
        .code_word  (seq_rd_data),
        .session    (session),
        .sl_flag    (sl_flag),
        .inven_flag (inven_flag)
    );

endmodule

`default_nettype wire

// ==== dv/tb_tag_mem.sv ====
// random traffic from a fixed LFSR seed; the macro model answers reads combinationally on mem_address
`timescale 1ns/1ps
`default_nettype none
`include "tag_mem_defs.svh"

module tb_tag_mem import tag_mem_pkg::*; ();

    // samples, selects and words read, rounded up
    localparam int N_OPS     = 450;
    localparam int CYC_LIMIT = 40 * N_OPS + 1000;

    logic                 clk;
    logic                 reset;
    logic                 packet_complete;
    logic [`RX_CMD_W-1:0] rx_cmd;
    sel_target_t          sel_target;
    sel_action_t          sel_action;
    word_t                mask;
    logic [1:0]           membank;
    logic [7:0]           read_ptr;
    logic [7:0]           read_count;
    sensor_code_t         sensor_code;
    logic                 adc_ready;
    logic [7:0]           adc_data;
    logic [7:0]           time_stamp;
    word_t                mem_read_in;
    word_t                mem_data_out;
    word_addr_t           mem_address;
    mem_bank_t            mem_sel;
    logic                 pc_b;
    logic                 se;
    logic                 we;
    logic                 tx_bit;
    logic                 tx_bit_valid;
    logic                 tx_data_done;
    logic                 mem_done;
    logic                 sl_flag;
    logic                 inven_flag;
    session_t             session;

    word_t       mem [0:2][0:`TAG_BANK_DEPTH-1];  // macro model
    word_t       model_mem [0:1][0:`TAG_BANK_DEPTH-1];
    int          model_cnt [0:1];
    logic        model_sl;
    logic        model_inv;
    session_t    model_sess;
    logic [31:0] lfsr_q;
    logic        bits_q [$];
    word_t       exp_q [$];
    int          done_cnt;
    int          done_idx;
    int          wr_cnt;
    int          exp_wr;
    int          err_value;
    int          err_other;
    int          cycles;

    tag_mem_top u_tag_mem_top (
        .clk             (clk),
        .reset           (reset),
        .packet_complete (packet_complete),
        .rx_cmd          (rx_cmd),
        .sel_target      (sel_target),
        .sel_action      (sel_action),
        .mask            (mask),
        .membank         (membank),
        .read_ptr        (read_ptr),
        .read_count      (read_count),
        .sensor_code     (sensor_code),
        .adc_ready       (adc_ready),
        .adc_data        (adc_data),
        .time_stamp      (time_stamp),
        .mem_read_in     (mem_read_in),
        .mem_data_out    (mem_data_out),
        .mem_address     (mem_address),
        .mem_sel         (mem_sel),
        .pc_b            (pc_b),
        .se              (se),
        .we              (we),
        .tx_bit          (tx_bit),
        .tx_bit_valid    (tx_bit_valid),
        .tx_data_done    (tx_data_done),
        .mem_done        (mem_done),
        .sl_flag         (sl_flag),
        .inven_flag      (inven_flag),
        .session         (session)
    );

    always #4 clk = ~clk;

    function automatic int bank_index(input mem_bank_t b);
        case (b)
            bank_sensor1: bank_index = 1;
            bank_sensor2: bank_index = 2;
            default:      bank_index = 0;
        endcase
    endfunction

    assign mem_read_in = mem[bank_index(mem_sel)][mem_address];

    always @(posedge clk) begin
        if ((se || we) && pc_b) begin
            $display("macro strobed while pc_b was high at %0t", $time);
            err_other++;
        end
        if (we) begin
            mem[bank_index(mem_sel)][mem_address] = mem_data_out;
        end
    end

    // taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            r      = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // bit stream and pulse monitor
    always @(posedge clk) begin
        if (!reset) begin
            if (tx_bit_valid) begin
                bits_q.push_back(tx_bit);
            end
            if (tx_data_done) begin
                done_cnt++;
                done_idx = bits_q.size();
                if (!tx_bit_valid) begin
                    $display("tx_data_done pulsed without a valid bit at %0t", $time);
                    err_other++;
                end
            end
            if (mem_done) begin
                wr_cnt++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYC_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("FAILED %0t %s expected %h actual %h", $time, name, exp, act);
            err_value++;
        end
    endtask

    task automatic check_count(input string name, input word_addr_t exp, input word_addr_t act);
        if (exp !== act) begin
            $display("FAILED %0t %s expected %0d actual %0d", $time, name, exp, act);
            err_value++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("FAILED %0t %s expected %b actual %b", $time, name, exp, act);
            err_value++;
        end
    endtask

    task automatic check_flags(input logic exp_sl, input logic exp_inv, input session_t exp_s);
        check_bit("sl_flag", exp_sl, sl_flag);
        check_bit("inven_flag", exp_inv, inven_flag);
        if (exp_s !== session) begin
            $display("FAILED %0t session expected %0d actual %0d", $time, exp_s, session);
            err_value++;
        end
    endtask

    task automatic send_packet(input int cmd_bit, input logic [1:0] bank_field,
                               input logic [7:0] ptr, input logic [7:0] cnt,
                               input sensor_code_t code, input sel_target_t tgt,
                               input sel_action_t act, input word_t msk);
        @(posedge clk);
        #1;
        packet_complete = 1'b1;
        rx_cmd          = '0;
        rx_cmd[cmd_bit] = 1'b1;
        membank         = bank_field;
        read_ptr        = ptr;
        read_count      = cnt;
        sensor_code     = code;
        sel_target      = tgt;
        sel_action      = act;
        mask            = msk;
        @(posedge clk);
        #1;
        packet_complete = 1'b0;
    endtask

    task automatic send_sample(input sensor_code_t code, input logic [7:0] d,
                               input logic [7:0] ts);
        int b;
        int n;
        @(posedge clk);
        #1;
        adc_ready   = 1'b1;
        sensor_code = code;
        adc_data    = d;
        time_stamp  = ts;
        @(posedge clk);
        #1;
        adc_ready = 1'b0;
        if ((code == 3'd1 || code == 3'd2) && model_cnt[code - 1] < `TAG_BANK_DEPTH) begin
            b = code - 1;
            model_mem[b][model_cnt[b]] = {ts, d};
            model_cnt[b]++;
            exp_wr++;
            n = 0;
            while (wr_cnt < exp_wr && n < 60) begin
                @(posedge clk);
                n++;
            end
            if (wr_cnt < exp_wr) begin
                $display("no mem_done for the sample sent at %0t", $time);
                err_other++;
                wr_cnt = exp_wr;
            end
        end else begin
            repeat (10) @(posedge clk);
        end
    endtask

    task automatic wait_tx_done(input int limit);
        int n;
        n = 0;
        while (done_cnt == 0 && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (done_cnt == 0) begin
            $display("reply never ended with tx_data_done at %0t", $time);
            err_other++;
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic clear_stream();
        bits_q.delete();
        exp_q.delete();
        done_cnt = 0;
        done_idx = 0;
    endtask

    // compares collected bits with the words in exp_q, LSB first
    task automatic check_stream();
        word_t w;
        check_word("bit count", exp_q.size() * 16, bits_q.size());
        if (exp_q.size() != 0) begin
            check_word("tx_data_done count", 1, done_cnt);
            check_word("tx_data_done bit index", exp_q.size() * 16, done_idx);
        end
        for (int i = 0; i < exp_q.size() && (i * 16 + 15) < bits_q.size(); i++) begin
            for (int j = 0; j < 16; j++) begin
                w[j] = bits_q[i * 16 + j];
            end
            check_word("tx word", exp_q[i], w);
        end
    endtask

    task automatic sensor_read(input int b);
        clear_stream();
        for (int a = model_cnt[b] - 1; a >= 0; a--) begin
            exp_q.push_back(model_mem[b][a]);
        end
        send_packet(`CMD_BIT_SENSOR_READ, 2'd0, 8'd0, 8'd0, b + 1, 3'd0, 3'd0, 16'd0);
        if (model_cnt[b] == 0) begin
            repeat (40) @(posedge clk);
        end else begin
            wait_tx_done(30 * model_cnt[b] + 60);  // 16 bits plus one access per word
        end
        check_stream();
    endtask

    task automatic epc_read(input logic [1:0] bank_field, input int ptr, input int cnt);
        clear_stream();
        if (bank_field == `MEMBANK_EPC) begin
            for (int a = ptr + cnt - 1; a >= ptr; a--) begin
                exp_q.push_back(mem[0][a]);
            end
        end
        send_packet(`CMD_BIT_READ, bank_field, ptr, cnt, 3'd0, 3'd0, 3'd0, 16'd0);
        if (bank_field == `MEMBANK_EPC) begin
            wait_tx_done(30 * cnt + 60);
        end else begin
            repeat (60) @(posedge clk);  // nothing may come out
        end
        check_stream();
    endtask

    task automatic select_once();
        sel_target_t tgt;
        sel_action_t act;
        word_t       msk;
        logic        hit;
        logic        cur;
        logic        nxt;
        int          n;
        tgt = rand_bits(3);
        act = rand_bits(3);
        msk = rand_bits(1) ? mem[0][`SELECT_CODE_ADDR] : word_t'(rand_bits(16));
        hit = (msk == mem[0][`SELECT_CODE_ADDR]);
        cur = (tgt < 3'd4) ? model_inv : model_sl;
        nxt = cur;
        if (hit) begin
            if (act == 0 || act == 1) nxt = 1'b1;
            if (act == 3) nxt = ~cur;
            if (act == 4 || act == 5) nxt = 1'b0;
        end else begin
            if (act == 0 || act == 2) nxt = 1'b0;
            if (act == 4 || act == 6) nxt = 1'b1;
            if (act == 7) nxt = ~cur;
        end
        if (tgt < 3'd4) begin
            model_inv  = nxt;
            model_sess = tgt[1:0];
        end else if (tgt == 3'd4) begin
            model_sl = nxt;
        end
        send_packet(`CMD_BIT_SELECT, `MEMBANK_EPC, 8'd0, 8'd0, 3'd0, tgt, act, msk);
        n = 0;
        while (!se && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (!se) begin
            $display("select never read the code word at %0t", $time);
            err_other++;
        end
        repeat (6) @(posedge clk);
        check_flags(model_sl, model_inv, model_sess);
    endtask

    task automatic mixed_samples();
        repeat (3) begin
            repeat (5) @(posedge clk);
            send_sample(1 + rand_bits(1), rand_bits(8), rand_bits(8));
        end
    endtask

    initial begin
        int ptr;
        int cnt;
        clk = 1'b0;
        reset = 1'b1;
        packet_complete = 1'b0;
        rx_cmd = '0;
        sel_target = '0;
        sel_action = '0;
        mask = '0;
        membank = '0;
        read_ptr = '0;
        read_count = '0;
        sensor_code = '0;
        adc_ready = 1'b0;
        adc_data = '0;
        time_stamp = '0;
        lfsr_q = 32'h0b66_cd73;
        err_value = 0;
        err_other = 0;
        cycles = 0;
        wr_cnt = 0;
        exp_wr = 0;
        model_cnt[0] = 0;
        model_cnt[1] = 0;
        model_sl = 1'b1;
        model_inv = 1'b1;
        model_sess = '0;
        clear_stream();
        for (int a = 0; a < `TAG_BANK_DEPTH; a++) begin
            mem[0][a] = rand_bits(16);
            mem[1][a] = '0;
            mem[2][a] = '0;
            model_mem[0][a] = '0;
            model_mem[1][a] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        check_flags(1'b1, 1'b1, 2'd0);
        check_bit("pc_b", 1'b1, pc_b);
        check_bit("se", 1'b0, se);
        check_bit("we", 1'b0, we);
        check_bit("mem_done", 1'b0, mem_done);

        repeat (40) begin
            send_sample(rand_bits(3), rand_bits(8), rand_bits(8));
        end
        check_count("mem_done pulses", exp_wr, wr_cnt);
        for (int b = 0; b < 2; b++) begin
            for (int a = 0; a < `TAG_BANK_DEPTH; a++) begin
                check_word("sensor bank word", model_mem[b][a], mem[b + 1][a]);
            end
        end

        sensor_read(0);
        sensor_read(1);

        for (int k = 0; k < 12; k++) begin
            ptr = rand_bits(6);
            cnt = 1 + rand_bits(3);
            if (ptr + cnt > `TAG_BANK_DEPTH) begin
                cnt = `TAG_BANK_DEPTH - ptr;
            end
            epc_read((k % 4 == 3) ? 2'd2 : `MEMBANK_EPC, ptr, cnt);
        end

        repeat (24) begin
            select_once();
        end

        repeat (3) begin
            ptr = rand_bits(5);
            fork
                epc_read(`MEMBANK_EPC, ptr, 8);
                mixed_samples();
            join
        end
        check_count("mem_done pulses", exp_wr, wr_cnt);
        sensor_read(0);
        sensor_read(1);

        $display("errors: %0d wrong values, %0d other failures", err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
src/tag_mem_pkg.sv
src/select_flags.sv
src/bank_sequencer.sv
src/command_ctrl.sv
src/word_serializer.sv
src/tag_mem_top.sv
dv/tb_tag_mem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs the tag memory controller testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_tag_mem -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_tag_mem > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error"
    cat sim.log
    exit 1
fi

cat sim.log

if grep -q "^STATUS: PASS$" sim.log; then
    exit 0
else
    exit 1
fi
